// File: include/sched_defines.svh
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// Core array size
`define NUM_CORES 4

// Task memory depth in frames
`define TM_DEPTH 16

// Parts broadcast per instruction frame, one per cycle
`define LOAD_TIME 4

`define PART_WIDTH 32

// R0 init value width per core
`define REG_WIDTH 16

// Width of the instruction frame count field
`define INSN_COUNT_WIDTH 4

// One memory frame holds all parts of an instruction frame
`define FRAME_WIDTH (`LOAD_TIME * `PART_WIDTH)

`endif

// File: logic/core_if_pkg.sv
`include "sched_defines.svh"

package core_if_pkg;

	// One bit per core
	typedef logic [`NUM_CORES-1:0] core_mask_t;

	typedef logic [`REG_WIDTH-1:0] reg_word_t;

	// Core 0 in the low word
	typedef reg_word_t [`NUM_CORES-1:0] r0_bus_t;

	typedef logic [`PART_WIDTH-1:0] insn_part_t;

	typedef logic [$clog2(`LOAD_TIME)-1:0] part_idx_t;

endpackage

// File: logic/task_frame_pkg.sv
`include "sched_defines.svh"

package task_frame_pkg;

	typedef enum logic [1:0] {
		NO  = 2'd0, // Overlap allowed
		ACQ = 2'd1, // Next task waits for all cores
		REL = 2'd2  // This task waits for all cores
	} fence_t;

	localparam int TM_ADDR_WIDTH = $clog2(`TM_DEPTH);

	typedef logic [`FRAME_WIDTH-1:0] frame_t;

	typedef logic [TM_ADDR_WIDTH-1:0] tm_addr_t;

	// Bits left over once the control fields are placed
	localparam int CTRL_PAD_WIDTH = `FRAME_WIDTH - `INSN_COUNT_WIDTH
		- 2 * `NUM_CORES - $bits(fence_t) - 1 - TM_ADDR_WIDTH
		- `NUM_CORES * `REG_WIDTH;

	// First field sits at the top of the frame
	typedef struct packed {
		logic [`INSN_COUNT_WIDTH-1:0] insn_count;
		core_if_pkg::core_mask_t      core_mask;
		fence_t                       fence;
		core_if_pkg::core_mask_t      init_mask;
		logic                         stop;      // Hand over to display
		tm_addr_t                     stop_addr; // Restart point
		core_if_pkg::r0_bus_t         r0;
		logic [CTRL_PAD_WIDTH-1:0]    pad;
	} ctrl_frame_t;

endpackage

// File: logic/task_memory.sv
`timescale 1ns/1ns
`include "sched_defines.svh"

module task_memory (
	input  logic                     clk,
	input  logic                     tm_we,
	input  task_frame_pkg::tm_addr_t tm_addr,
	input  task_frame_pkg::frame_t   tm_wdata,
	input  task_frame_pkg::tm_addr_t tm_ptr,
	output task_frame_pkg::frame_t   frame
);

	import task_frame_pkg::*;

	frame_t mem [`TM_DEPTH];

	// Write port stays live during reset so the program can be loaded
	always_ff @(posedge clk) begin
		if (tm_we) begin
			mem[tm_addr] <= tm_wdata;
		end
	end

	assign frame = mem[tm_ptr]; // Async read at task pointer

	a_addr_in_range: assert property (
		@(posedge clk) tm_we |-> int'(tm_addr) < `TM_DEPTH
	);

endmodule

// File: logic/sched_fsm.sv
`timescale 1ns/1ns
`include "sched_defines.svh"

module sched_fsm (
	input  logic                     clk,
	input  logic                     reset,
	input  task_frame_pkg::frame_t   frame,
	input  core_if_pkg::core_mask_t  ready,
	input  logic                     cores_done,
	input  logic                     last_part,
	input  logic                     start_issue,
	output task_frame_pkg::tm_addr_t tm_ptr,
	output logic                     load_ctrl,
	output logic                     loading,
	output logic                     vga_en,
	input  logic                     vga_end
);

	import task_frame_pkg::*;

	typedef enum logic [1:0] {
		CTRL,
		LOAD,
		DISPLAY
	} state_t;

	state_t                       state;
	ctrl_frame_t                  ctrl;
	fence_t                       fence_r;
	logic [`INSN_COUNT_WIDTH-1:0] frames_left;
	logic                         stop_r;
	tm_addr_t                     stop_addr_r;
	logic                         vga_sent;
	logic                         all_ready;
	logic                         own_ready;
	logic                         block_all;
	logic                         frame_end;

	assign ctrl      = frame;
	assign all_ready = &ready;
	assign own_ready = (ready & ctrl.core_mask) == ctrl.core_mask;

	// Wait for the whole array after an ACQ task or for a fenced task
	assign block_all = (fence_r == ACQ) || (ctrl.fence != NO);

	assign load_ctrl = (state == CTRL) && (block_all ? all_ready : own_ready);
	assign loading   = (state == LOAD);
	assign frame_end = start_issue && last_part;
	assign vga_en    = (state == DISPLAY) && !vga_sent && all_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= CTRL;
			tm_ptr      <= '0;
			fence_r     <= NO;
			frames_left <= '0;
			stop_r      <= 1'b0;
			vga_sent    <= 1'b0;
		end else begin
			case (state)
				CTRL: begin
					if (load_ctrl) begin
						tm_ptr      <= tm_ptr + 1'b1;
						fence_r     <= ctrl.fence;
						frames_left <= ctrl.insn_count;
						stop_r      <= ctrl.stop;
						if (ctrl.insn_count != '0) begin
							state <= LOAD;
						end else if (ctrl.stop) begin
							state <= DISPLAY; // Stop task without frames
						end
					end
				end
				LOAD: begin
					if (frame_end) begin
						tm_ptr      <= tm_ptr + 1'b1;
						frames_left <= frames_left - 1'b1;
						if (frames_left == `INSN_COUNT_WIDTH'd1) begin
							state <= stop_r ? DISPLAY : CTRL;
						end
					end
				end
				DISPLAY: begin
					if (vga_en) begin
						vga_sent <= 1'b1;
					end else if (vga_sent && vga_end) begin
						vga_sent <= 1'b0;
						stop_r   <= 1'b0;
						tm_ptr   <= stop_addr_r;
						fence_r  <= ACQ; // Restart waits for idle array
						state    <= CTRL;
					end
				end
				default: begin
					state <= CTRL;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_ctrl) begin
			stop_addr_r <= ctrl.stop_addr;
		end
	end

	a_vga_single: assert property (
		@(posedge clk) disable iff (reset) vga_en |=> !vga_en
	);

	a_load_ctrl_state: assert property (
		@(posedge clk) disable iff (reset) load_ctrl |-> state == CTRL
	);

	// Broadcast only issues parts while this FSM is loading
	a_issue_in_load: assert property (
		@(posedge clk) disable iff (reset) start_issue |-> loading && cores_done
	);

endmodule

// File: logic/load_timer.sv
`timescale 1ns/1ns
`include "sched_defines.svh"

module load_timer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   load_ctrl,
	input  logic                   start_issue,
	output core_if_pkg::part_idx_t insn_load_counter,
	output logic                   last_part
);

	import core_if_pkg::*;

	localparam part_idx_t LAST_IDX = part_idx_t'(`LOAD_TIME - 1);

	// Holds while the cores push back
	always_ff @(posedge clk) begin
		if (reset || load_ctrl) begin
			insn_load_counter <= '0;
		end else if (start_issue) begin
			if (last_part) begin
				insn_load_counter <= '0;
			end else begin
				insn_load_counter <= insn_load_counter + 1'b1;
			end
		end
	end

	assign last_part = (insn_load_counter == LAST_IDX);

endmodule

// File: logic/insn_broadcast.sv
`timescale 1ns/1ns
`include "sched_defines.svh"

module insn_broadcast (
	input  logic                    clk,
	input  logic                    reset,
	input  task_frame_pkg::frame_t  frame,
	input  logic                    load_ctrl,
	input  logic                    loading,
	input  core_if_pkg::core_mask_t ready,
	input  core_if_pkg::part_idx_t  insn_load_counter,
	output logic                    cores_done,
	output logic                    start_issue,
	output core_if_pkg::core_mask_t start,
	output core_if_pkg::insn_part_t insn_data
);

	import task_frame_pkg::*;
	import core_if_pkg::*;

	ctrl_frame_t                 ctrl;
	core_mask_t                  active_mask;
	insn_part_t [`LOAD_TIME-1:0] parts;

	assign ctrl  = frame;
	assign parts = frame; // Part 0 in the low bits

	always_ff @(posedge clk) begin
		if (reset) begin
			active_mask <= '0;
		end else if (load_ctrl) begin
			active_mask <= ctrl.core_mask;
		end
	end

	// Busy is a low ready bit
	assign cores_done = ((~ready & active_mask) == '0);

	assign start_issue = loading && cores_done;

	assign start = start_issue ? active_mask : '0;

	assign insn_data = parts[insn_load_counter];

	a_start_in_mask: assert property (
		@(posedge clk) disable iff (reset) (start & ~active_mask) == '0
	);

endmodule

// File: logic/core_init_regs.sv
`timescale 1ns/1ns

module core_init_regs (
	input  logic                    clk,
	input  logic                    reset,
	input  task_frame_pkg::frame_t  frame,
	input  logic                    load_ctrl,
	output core_if_pkg::core_mask_t init_r0_vect,
	output core_if_pkg::r0_bus_t    init_r0
);

	import task_frame_pkg::*;

	ctrl_frame_t ctrl;

	assign ctrl = frame;

	// Held for the whole task, replaced by the next control frame
	always_ff @(posedge clk) begin
		if (reset) begin
			init_r0_vect <= '0;
			init_r0      <= '0;
		end else if (load_ctrl) begin
			init_r0_vect <= ctrl.init_mask;
			init_r0      <= ctrl.r0;
		end
	end

endmodule

// File: logic/task_scheduler_top.sv
`timescale 1ns/1ns

module task_scheduler_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     tm_we,
	input  task_frame_pkg::tm_addr_t tm_addr,
	input  task_frame_pkg::frame_t   tm_wdata,
	input  core_if_pkg::core_mask_t  ready,
	output core_if_pkg::core_mask_t  start,
	output core_if_pkg::part_idx_t   insn_load_counter,
	output core_if_pkg::insn_part_t  insn_data,
	output core_if_pkg::core_mask_t  init_r0_vect,
	output core_if_pkg::r0_bus_t     init_r0,
	output logic                     vga_en,
	input  logic                     vga_end
);

	import task_frame_pkg::*;

	frame_t   frame;
	tm_addr_t tm_ptr;
	logic     load_ctrl;
	logic     loading;
	logic     cores_done;
	logic     last_part;
	logic     start_issue;

	task_memory i_task_memory (
		.clk      (clk),
		.tm_we    (tm_we),
		.tm_addr  (tm_addr),
		.tm_wdata (tm_wdata),
		.tm_ptr   (tm_ptr),
		.frame    (frame)
	);

	sched_fsm i_sched_fsm (
		.clk         (clk),
		.reset       (reset),
		.frame       (frame),
		.ready       (ready),
		.cores_done  (cores_done),
		.last_part   (last_part),
		.start_issue (start_issue),
		.tm_ptr      (tm_ptr),
		.load_ctrl   (load_ctrl),
		.loading     (loading),
		.vga_en      (vga_en),
		.vga_end     (vga_end)
	);

	load_timer i_load_timer (
		.clk               (clk),
		.reset             (reset),
		.load_ctrl         (load_ctrl),
		.start_issue       (start_issue),
		.insn_load_counter (insn_load_counter),
		.last_part         (last_part)
	);

	insn_broadcast i_insn_broadcast (
		.clk               (clk),
		.reset             (reset),
		.frame             (frame),
		.load_ctrl         (load_ctrl),
		.loading           (loading),
		.ready             (ready),
		.insn_load_counter (insn_load_counter),
		.cores_done        (cores_done),
		.start_issue       (start_issue),
		.start             (start),
		.insn_data         (insn_data)
	);

	core_init_regs i_core_init_regs (
		.clk          (clk),
		.reset        (reset),
		.frame        (frame),
		.load_ctrl    (load_ctrl),
		.init_r0_vect (init_r0_vect),
		.init_r0      (init_r0)
	);

endmodule

// File: verification/task_scheduler_tb.sv
`timescale 1ns/1ns
`include "sched_defines.svh"

module task_scheduler_tb;

	import task_frame_pkg::*;
	import core_if_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int LOOPS = 3;
	localparam int NUM_TASKS = 4;
	localparam int TASK_A = 0;
	localparam int TASK_B = 1;
	localparam int FRAME_BUDGET = 20; // Four parts at worst-case busy plus accept wait
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * (9 + 1) * FRAME_BUDGET;

	localparam int NUM_TESTS = 6;
	localparam int T_RESET = 0;
	localparam int T_BROADCAST = 1;
	localparam int T_ORDER = 2;
	localparam int T_FENCE = 3;
	localparam int T_INIT = 4;
	localparam int T_DISPLAY = 5;

	// Program A, B, C, D
	localparam core_mask_t TASK_MASK [NUM_TASKS] = '{4'b0011, 4'b1100, 4'b1111, 4'b0101};
	localparam core_mask_t TASK_INIT [NUM_TASKS] = '{4'b0001, 4'b1100, 4'b1010, 4'b0101};
	localparam fence_t TASK_FENCE [NUM_TASKS] = '{NO, NO, REL, ACQ};
	localparam int TASK_COUNT [NUM_TASKS] = '{2, 1, 1, 1};
	localparam logic TASK_STOP [NUM_TASKS] = '{1'b0, 1'b0, 1'b0, 1'b1};

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic tm_we = 1'b0;
	tm_addr_t tm_addr = '0;
	frame_t tm_wdata = '0;
	core_mask_t ready = '1;
	logic vga_end = 1'b0;
	core_mask_t start;
	part_idx_t insn_load_counter;
	insn_part_t insn_data;
	core_mask_t init_r0_vect;
	r0_bus_t init_r0;
	logic vga_en;

	frame_t prog [`TM_DEPTH];
	int ctrl_addr [NUM_TASKS];
	int prog_len;
	logic [31:0] lfsr = 32'h2aa0_ce38;
	logic [1:0] busy [`NUM_CORES];
	logic [3:0] disp_wait = '0;

	int checks [NUM_TESTS] = '{default: 0};
	int errors [NUM_TESTS] = '{default: 0};

	// Predicted position in the program
	int exp_task = 0;
	int exp_frame = 0;
	int exp_part = 0;
	int restarts = 0;
	logic reset_q = 1'b0;
	logic all_ready_seen = 1'b0;
	logic overlap_seen = 1'b0;
	logic d_pending = 1'b0;
	logic in_display = 1'b0;
	logic after_display = 1'b0;

	task_scheduler_top i_task_scheduler_top (
		.clk               (clk),
		.reset             (reset),
		.tm_we             (tm_we),
		.tm_addr           (tm_addr),
		.tm_wdata          (tm_wdata),
		.ready             (ready),
		.start             (start),
		.insn_load_counter (insn_load_counter),
		.insn_data         (insn_data),
		.init_r0_vect      (init_r0_vect),
		.init_r0           (init_r0),
		.vga_en            (vga_en),
		.vga_end           (vga_end)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [3:0] random_bits(input int count);
		logic [3:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[2:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return value;
	endfunction

	function automatic r0_bus_t task_r0(input int t);
		r0_bus_t bus;
		for (int c = 0; c < `NUM_CORES; c++) begin
			bus[c] = {4'(t + 1), 4'(c), 8'h3c ^ 8'(t * 16 + c)};
		end
		return bus;
	endfunction

	// Every field tied to the frame address
	function automatic insn_part_t insn_part(input int addr, input int part);
		return {8'h5a ^ 8'(addr), 4'(addr), 4'(part), 16'(addr * 'h0123 + part * 'h1011)};
	endfunction

	function automatic string test_name(input int t);
		case (t)
			T_RESET: return "reset";
			T_BROADCAST: return "broadcast";
			T_ORDER: return "part_order";
			T_FENCE: return "fence";
			T_INIT: return "init_regs";
			default: return "display";
		endcase
	endfunction

	function automatic void count_check(input int test);
		checks[test]++;
	endfunction

	task automatic value_mismatch(input int test, input string what,
			input logic [127:0] expected, input logic [127:0] actual);
		errors[test]++;
		$display("Fail %s %s: expected %0h, actual %0h at %0t", test_name(test), what,
			expected, actual, $time);
	endtask

	task automatic other_failure(input int test, input string what);
		errors[test]++;
		$display("Error in %s test: %s at %0t", test_name(test), what, $time);
	endtask

	task automatic build_program();
		ctrl_frame_t c;
		int a;
		a = 0;
		for (int t = 0; t < NUM_TASKS; t++) begin
			c = '0;
			c.insn_count = 4'(TASK_COUNT[t]);
			c.core_mask = TASK_MASK[t];
			c.fence = TASK_FENCE[t];
			c.init_mask = TASK_INIT[t];
			c.stop = TASK_STOP[t];
			c.stop_addr = '0; // Loop back to task A
			c.r0 = task_r0(t);
			ctrl_addr[t] = a;
			prog[a] = c;
			a++;
			for (int f = 0; f < TASK_COUNT[t]; f++) begin
				for (int p = 0; p < `LOAD_TIME; p++) begin
					prog[a][p * `PART_WIDTH +: `PART_WIDTH] = insn_part(a, p);
				end
				a++;
			end
		end
		prog_len = a;
	endtask

	// Cores go busy on start, display answers each vga_en
	always @(posedge clk) begin : core_and_display_model
		logic [3:0] draw;
		if (reset) begin
			ready <= '1;
			vga_end <= 1'b0;
			disp_wait <= '0;
			for (int i = 0; i < `NUM_CORES; i++) begin
				busy[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `NUM_CORES; i++) begin
				if (start[i]) begin
					draw = random_bits(2);
					busy[i] <= draw[1:0];
					ready[i] <= (draw == 4'd0);
				end else if (busy[i] != 2'd0) begin
					busy[i] <= busy[i] - 2'd1;
					ready[i] <= (busy[i] == 2'd1);
				end
			end
			vga_end <= 1'b0;
			if (vga_en) begin
				disp_wait <= 4'd1 + random_bits(3);
			end else if (disp_wait != 4'd0) begin
				disp_wait <= disp_wait - 4'd1;
				vga_end <= (disp_wait == 4'd1);
			end
		end
	end

	always @(posedge clk) begin : check_outputs
		int addr;
		logic first_start;
		logic last_of_frame;
		logic last_of_task;
		insn_part_t exp_data;
		insn_part_t restart_data;
		reset_q <= reset;
		addr = ctrl_addr[exp_task] + 1 + exp_frame;
		exp_data = prog[addr][exp_part * `PART_WIDTH +: `PART_WIDTH];
		restart_data = prog[ctrl_addr[TASK_A] + 1][`PART_WIDTH-1:0];
		first_start = (exp_frame == 0 && exp_part == 0);
		last_of_frame = (exp_part == `LOAD_TIME - 1);
		last_of_task = last_of_frame && (exp_frame == TASK_COUNT[exp_task] - 1);
		if (reset_q) begin
			count_check(T_RESET);
			assert (start == '0 && !vga_en && init_r0_vect == '0) else
				value_mismatch(T_RESET, "start,vga_en,init_r0_vect", 128'(0),
					128'({start, vga_en, init_r0_vect}));
		end
		if (!reset && start != '0) begin
			count_check(T_BROADCAST);
			assert (start == TASK_MASK[exp_task]) else
				value_mismatch(T_BROADCAST, "start", 128'(TASK_MASK[exp_task]), 128'(start));
			count_check(T_BROADCAST);
			assert ((start & ~ready) == '0) else
				other_failure(T_BROADCAST, "start sent to a core that was not ready");
			count_check(T_BROADCAST);
			assert (insn_data == exp_data) else
				value_mismatch(T_BROADCAST, "insn_data", 128'(exp_data), 128'(insn_data));
			count_check(T_ORDER);
			assert (int'(insn_load_counter) == exp_part) else
				value_mismatch(T_ORDER, "insn_load_counter", 128'(exp_part),
					128'(insn_load_counter));
			count_check(T_INIT);
			assert (init_r0_vect == TASK_INIT[exp_task]) else
				value_mismatch(T_INIT, "init_r0_vect", 128'(TASK_INIT[exp_task]),
					128'(init_r0_vect));
			count_check(T_INIT);
			assert (init_r0 == task_r0(exp_task)) else
				value_mismatch(T_INIT, "init_r0", 128'(task_r0(exp_task)), 128'(init_r0));
			count_check(T_DISPLAY);
			assert (!d_pending && !in_display) else
				other_failure(T_DISPLAY, "start issued while the display stop was open");
			if (first_start && TASK_FENCE[exp_task] != NO) begin
				count_check(T_FENCE);
				assert (all_ready_seen) else
					other_failure(T_FENCE, "fenced task started without an all-idle cycle");
			end
			if (exp_task == TASK_B && (ready & TASK_MASK[TASK_A]) != TASK_MASK[TASK_A]) begin
				overlap_seen <= 1'b1; // A still busy under B
			end
			if (after_display) begin
				count_check(T_DISPLAY);
				assert (start == TASK_MASK[TASK_A] && insn_data == restart_data) else
					value_mismatch(T_DISPLAY, "first part after display",
						128'(restart_data), 128'(insn_data));
				after_display <= 1'b0;
				restarts <= restarts + 1;
				if (restarts + 1 == LOOPS) begin
					count_check(T_FENCE);
					assert (overlap_seen) else
						other_failure(T_FENCE, "task B never started while task A was busy");
				end
			end
			exp_part <= last_of_frame ? 0 : exp_part + 1;
			if (last_of_task) begin
				exp_frame <= 0;
				exp_task <= (exp_task + 1) % NUM_TASKS;
				if (TASK_STOP[exp_task]) begin
					d_pending <= 1'b1;
				end
			end else if (last_of_frame) begin
				exp_frame <= exp_frame + 1;
			end
		end
		if (!reset) begin
			if (start != '0 && last_of_task) begin
				all_ready_seen <= 1'b0;
			end else if (&ready) begin
				all_ready_seen <= 1'b1;
			end
			if (vga_en) begin
				count_check(T_DISPLAY);
				assert (d_pending && !in_display) else
					other_failure(T_DISPLAY, "display pulse without a finished stop task");
				d_pending <= 1'b0;
				in_display <= 1'b1;
			end
			if (vga_end && in_display) begin
				in_display <= 1'b0;
				after_display <= 1'b1;
			end
		end
	end

	initial begin : run_program
		int total_checks;
		int total_errors;
		total_checks = 0;
		total_errors = 0;
		build_program();
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			if (i < prog_len) begin
				tm_we <= 1'b1;
				tm_addr <= tm_addr_t'(i);
				tm_wdata <= prog[i];
			end else begin
				tm_we <= 1'b0;
			end
			if (i == RESET_CYCLES - 1) begin
				reset <= 1'b0;
			end
		end
		wait (restarts == LOOPS);
		@(negedge clk);
		for (int t = 0; t < NUM_TESTS; t++) begin
			$display("Test %s: %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
			if (checks[t] == 0) begin
				$display("Error: test %s was never reached", test_name(t));
				total_errors++;
			end
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("Checks: %0d, errors: %0d", total_checks, total_errors);
		if (total_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: task_scheduler_top.f
+incdir+include
logic/core_if_pkg.sv
logic/task_frame_pkg.sv
logic/task_memory.sv
logic/sched_fsm.sv
logic/load_timer.sv
logic/insn_broadcast.sv
logic/core_init_regs.sv
logic/task_scheduler_top.sv
verification/task_scheduler_tb.sv

// File: Makefile
SOURCES = task_scheduler_top.f $(wildcard include/*.svh logic/*.sv verification/*.sv)

.PHONY: run clean

run: obj_dir/Vtask_scheduler_tb
	obj_dir/Vtask_scheduler_tb | tee sim.log
	grep -q "^Done: no errors$$" sim.log

obj_dir/Vtask_scheduler_tb: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f task_scheduler_top.f \
		--top-module task_scheduler_tb -o Vtask_scheduler_tb

clean:
	rm -rf obj_dir sim.log
